//--- all.f
hdl/cache_pkg.sv
hdl/fill_if.sv
hdl/tag_lookup.sv
hdl/miss_fill_fsm.sv
hdl/data_store.sv
hdl/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

//--- hdl/cache_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and constants for the read-only cache.
// Addresses are byte addresses of 16 bits, and data is one
// 16-bit word. A line is 8 words, so 16 bytes. Bit 0 of an
// address is ignored. The line count is set in the top level.
////////////////////////////////////////////////////////////
package cache_pkg;

  localparam int ADDR_BITS = 16;                    // Width of a byte address.
  localparam int WORD_BITS = 16;                    // Width of one data word.

  typedef logic [ADDR_BITS-1:0] addr_t;             // Byte address on the load and memory side.
  typedef logic [WORD_BITS-1:0] word_t;             // One data word.

  localparam int WORDS_PER_LINE = 8;                // Words per line, and the fill length.
  localparam int OFFSET_BITS    = 4;                // Byte offset bits within one line.
  localparam int WORD_SEL_BITS  = 3;                // Word select bits, address bits 3..1.
  localparam int MEM_STEP       = 2;                // Byte step between two fill words.

  // Bytes covered by one line, as an address offset.
  localparam addr_t LINE_BYTES = addr_t'(WORDS_PER_LINE * MEM_STEP);

  ////////////////////////////////////////////////////////////
  // Index width for a given number of lines.
  ////////////////////////////////////////////////////////////
  function automatic int line_index_bits(input int num_lines);
    int bits;                                       // Result, at least one bit.
    bits = $clog2(num_lines);                       // Power of two line counts are expected.
    if (bits < 1) begin
      bits = 1;                                     // A single line still needs an index bit.
    end
    return bits;
  endfunction

endpackage

//--- hdl/cache_top.sv
////////////////////////////////////////////////////////////
// Read-only direct-mapped cache, top level.
// Hits return one cycle after rd_en. Misses raise stall
// until the line is filled. Hold rd_en low during stall.
// NUM_LINES must be a power of two.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_top #(
  parameter int NUM_LINES = 8                       // Number of cache lines.
) (
  input  logic             clk,                     // Clock.
  input  logic             rst,                     // Synchronous reset, active high.
  input  logic             rd_en,                   // Load strobe.
  input  cache_pkg::addr_t rd_address,              // Load byte address.
  output logic             rd_valid,                // Load result valid.
  output cache_pkg::word_t rd_data,                 // Load result word.
  output logic             rd_hit,                  // Load hit on first lookup.
  output logic             stall,                   // Hold off new loads.
  output cache_pkg::addr_t memory_address,          // Address to memory.
  input  cache_pkg::word_t memory_data,             // Word from memory.
  input  logic             memory_data_valid        // Memory word valid.
);

  fill_if fill_bus ();                              // Fill writes to both arrays.

  logic             miss_detected;                  // Lookup starts a fill.
  cache_pkg::addr_t miss_address;                   // Address that missed.
  cache_pkg::addr_t req_address;                    // Pending load address.
  logic             hit;                            // Pending load hits.
  logic             fsm_busy;                       // Fill in progress.

  tag_lookup #(.NUM_LINES(NUM_LINES)) lookup_i (
    .clk           (clk),
    .rst           (rst),
    .rd_en         (rd_en),
    .rd_address    (rd_address),
    .fsm_busy      (fsm_busy),
    .fill          (fill_bus.lookup),
    .miss_detected (miss_detected),
    .miss_address  (miss_address),
    .req_address   (req_address),
    .hit           (hit),
    .rd_valid      (rd_valid),
    .rd_hit        (rd_hit),
    .stall         (stall)
  );

  miss_fill_fsm fsm_i (
    .clk               (clk),
    .rst               (rst),
    .miss_detected     (miss_detected),
    .miss_address      (miss_address),
    .memory_data       (memory_data),
    .memory_data_valid (memory_data_valid),
    .fsm_busy          (fsm_busy),
    .memory_address    (memory_address),
    .fill              (fill_bus.fsm)
  );

  data_store #(.NUM_LINES(NUM_LINES)) store_i (
    .clk         (clk),
    .fill        (fill_bus.store),
    .req_address (req_address),
    .hit         (hit),
    .rd_data     (rd_data)
  );

endmodule

//--- hdl/data_store.sv
////////////////////////////////////////////////////////////
// Data array of NUM_LINES lines of 8 words each.
// Written word by word during a fill and read without a
// clock edge. rd_data is zero unless the lookup hits.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_store #(
  parameter int NUM_LINES = 8                       // Number of cache lines.
) (
  input  logic             clk,                     // Clock.
  fill_if.store            fill,                    // Fill word writes.
  input  cache_pkg::addr_t req_address,             // Pending load address.
  input  logic             hit,                     // Pending load hits this cycle.
  output cache_pkg::word_t rd_data                  // Load result word.
);
  import cache_pkg::*;

  localparam int IDX_BITS = line_index_bits(NUM_LINES);  // Line index width.
  localparam int PTR_BITS = IDX_BITS + WORD_SEL_BITS;    // Word pointer width.
  localparam int DEPTH    = NUM_LINES * WORDS_PER_LINE;  // Total words held.

  word_t               data_mem [DEPTH];            // The word array.
  logic [PTR_BITS-1:0] wr_ptr;                      // Word written by the fill.
  logic [PTR_BITS-1:0] rd_ptr;                      // Word read for the load.

  ////////////////////////////////////////////////////////////
  // Word pointers
  ////////////////////////////////////////////////////////////
  // Index bits and word select bits side by side give the flat pointer.
  assign wr_ptr = {fill.fill_address[OFFSET_BITS +: IDX_BITS],
                   fill.fill_address[1 +: WORD_SEL_BITS]};
  assign rd_ptr = {req_address[OFFSET_BITS +: IDX_BITS],
                   req_address[1 +: WORD_SEL_BITS]}; // Odd byte addresses map to their word.

  ////////////////////////////////////////////////////////////
  // Write and read
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fill.write_data_array) begin
      data_mem[wr_ptr] <= fill.fill_data;           // One word per memory pulse.
    end
  end

  // Hit data goes out in the same cycle as rd_valid.
  assign rd_data = hit ? data_mem[rd_ptr] : '0;

endmodule

//--- hdl/fill_if.sv
////////////////////////////////////////////////////////////
// Fill write bus from the miss FSM to both arrays.
// Data writes pulse once per returned word; the tag write
// pulses once, after the last word of the line.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface fill_if;
  import cache_pkg::*;

  logic  write_data_array;                          // One pulse per word returned by memory.
  logic  write_tag_array;                           // One pulse when the whole line is in.
  addr_t fill_address;                              // Current memory address of the fill.
  word_t fill_data;                                 // Word to be stored in the data array.

  // Driving side, the fill controller.
  modport fsm (output write_data_array, output write_tag_array,
               output fill_address, output fill_data);

  // Tag side only needs the tag strobe and the address.
  modport lookup (input write_tag_array, input fill_address);

  // Data side takes every word.
  modport store (input write_data_array, input fill_address, input fill_data);

endinterface

//--- hdl/miss_fill_fsm.sv
////////////////////////////////////////////////////////////
// Line fill controller for cache misses.
// Memory gets only an address and answers with valid pulses.
// Any gap between pulses is allowed, and the FSM waits for
// as long as it takes. One miss is handled at a time.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module miss_fill_fsm (
  input  logic             clk,                     // Clock.
  input  logic             rst,                     // Synchronous reset, active high.
  input  logic             miss_detected,           // Miss from the tag lookup.
  input  cache_pkg::addr_t miss_address,            // Address that missed.
  input  cache_pkg::word_t memory_data,             // Word returned by memory.
  input  logic             memory_data_valid,       // Memory word is valid this cycle.
  output logic             fsm_busy,                // Fill in progress.
  output cache_pkg::addr_t memory_address,          // Address presented to memory.
  fill_if.fsm              fill                     // Writes into the tag and data arrays.
);
  import cache_pkg::*;

  typedef enum logic {IDLE, WAIT} state_t;          // Idle, or waiting on memory words.

  state_t     state;                                // Current state.
  state_t     nxt_state;                            // Next state.
  logic       clr_count;                            // Start a new fill.
  logic       incr_cnt;                             // One more word has arrived.
  logic [3:0] word_count;                           // Words written so far.
  logic       chunks_filled;                        // All words of the line are in.
  logic       error;                                // FSM left its legal states.

  ////////////////////////////////////////////////////////////
  // Word counter and memory address
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      word_count <= 4'h0;                           // Nothing filled after reset.
    end else if (clr_count) begin
      word_count <= 4'h0;                           // Fresh count for a new miss.
    end else if (incr_cnt) begin
      word_count <= word_count + 4'h1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_address <= '0;
    end else if (clr_count) begin
      // Start at the first word of the line.
      memory_address <= {miss_address[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
    end else if (incr_cnt) begin
      memory_address <= memory_address + addr_t'(MEM_STEP); // Next word of the line.
    end
  end

  assign chunks_filled = (word_count == 4'(WORDS_PER_LINE)); // Count ends at eight.

  ////////////////////////////////////////////////////////////
  // State register and transitions
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state             = state;                  // Hold by default.
    clr_count             = 1'b0;
    incr_cnt              = 1'b0;
    fsm_busy              = 1'b0;
    fill.write_data_array = 1'b0;
    fill.write_tag_array  = 1'b0;
    fill.fill_data        = '0;                     // Quiet bus when nothing is written.
    error                 = 1'b0;

    case (state)
      IDLE: begin
        if (miss_detected) begin
          clr_count = 1'b1;                         // Capture the line address.
          nxt_state = WAIT;
        end
      end

      WAIT: begin
        if (chunks_filled) begin
          fill.write_tag_array = 1'b1;              // Line complete, publish the tag.
          nxt_state            = IDLE;              // Busy drops in this last cycle.
        end else begin
          fsm_busy = 1'b1;
          if (memory_data_valid) begin
            incr_cnt              = 1'b1;
            fill.write_data_array = 1'b1;           // Store the word in the same cycle.
            fill.fill_data        = memory_data;
          end
        end
      end

      default: begin
        nxt_state = IDLE;                           // Recover to idle.
        error     = 1'b1;
      end
    endcase
  end

  assign fill.fill_address = memory_address;        // Arrays use the live fill address.

  // Self checks
  a_no_error: assert property (@(posedge clk) disable iff (rst) !error)
    else $error("Fill FSM reached an illegal state.");

  // A data write lands in the word slot that the word count has reached.
  a_write_in_wait: assert property (@(posedge clk) disable iff (rst)
    fill.write_data_array |-> (state == WAIT) &&
      (memory_address[OFFSET_BITS-1:1] == word_count[WORD_SEL_BITS-1:0]))
    else $error("Data array written outside a fill or at the wrong word.");

endmodule

//--- hdl/tag_lookup.sv
////////////////////////////////////////////////////////////
// Load request register with tag and valid arrays.
// A hit is seen one cycle after rd_en. A miss holds the
// request and stalls until the fill has written the tag.
// rd_en must stay low while stall is high.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tag_lookup #(
  parameter int NUM_LINES = 8                       // Number of cache lines.
) (
  input  logic             clk,                     // Clock.
  input  logic             rst,                     // Synchronous reset, active high.
  input  logic             rd_en,                   // Load strobe from the processor.
  input  cache_pkg::addr_t rd_address,              // Load byte address.
  input  logic             fsm_busy,                // Fill in progress.
  fill_if.lookup           fill,                    // Tag writes from the fill controller.
  output logic             miss_detected,           // One cycle per pending miss.
  output cache_pkg::addr_t miss_address,            // Address that missed.
  output cache_pkg::addr_t req_address,             // Pending address for the data array.
  output logic             hit,                     // Pending request hits this cycle.
  output logic             rd_valid,                // Load result is valid.
  output logic             rd_hit,                  // Load hit on its first lookup.
  output logic             stall                    // Processor must hold off.
);
  import cache_pkg::*;

  localparam int IDX_BITS = line_index_bits(NUM_LINES);         // Line index width.
  localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - IDX_BITS; // Stored tag width.

  addr_t                pend_addr;                  // Registered request address.
  logic                 pend_valid;                 // A request is waiting for its result.
  logic                 first_miss;                 // The request missed at first lookup.
  logic [NUM_LINES-1:0] line_valid;                 // One valid bit per line.
  logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];        // Tag array.
  logic [IDX_BITS-1:0]  rd_idx;                     // Index of the pending request.
  logic [TAG_BITS-1:0]  rd_tag;                     // Tag of the pending request.
  addr_t                line_base;                  // First address of the filled line.
  logic [IDX_BITS-1:0]  wr_idx;                     // Index written by the fill.
  logic [TAG_BITS-1:0]  wr_tag;                     // Tag written by the fill.

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////
  assign rd_idx = pend_addr[OFFSET_BITS +: IDX_BITS];    // Index bits sit above the offset.
  assign rd_tag = pend_addr[ADDR_BITS-1 -: TAG_BITS];    // Tag is the rest of the address.

  assign hit      = pend_valid && line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign stall    = pend_valid && !hit;                  // Held until the line is resident.
  assign rd_valid = hit;                                 // A result always comes from a hit.
  assign rd_hit   = hit && !first_miss;                  // A refilled load reports its miss.

  // The tag strobe cycle still misses, so it must not start a second fill.
  assign miss_detected = stall && !fsm_busy && !fill.write_tag_array;

  assign miss_address = pend_addr;                       // The FSM aligns it to the line.
  assign req_address  = pend_addr;                       // Same address reads the data array.

  ////////////////////////////////////////////////////////////
  // Pending request
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;                                // No request after reset.
      first_miss <= 1'b0;
    end else if (rd_en) begin
      pend_valid <= 1'b1;                                // New request replaces a delivered one.
      first_miss <= 1'b0;
    end else if (rd_valid) begin
      pend_valid <= 1'b0;                                // Result delivered, nothing pending.
    end else if (stall) begin
      first_miss <= 1'b1;                                // Remember the miss until delivery.
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      pend_addr <= rd_address;                           // Payload only, no reset.
    end
  end

  ////////////////////////////////////////////////////////////
  // Tag update
  ////////////////////////////////////////////////////////////
  // The fill address has already stepped past the last word of the line.
  assign line_base = fill.fill_address - LINE_BYTES;
  assign wr_idx    = line_base[OFFSET_BITS +: IDX_BITS];
  assign wr_tag    = line_base[ADDR_BITS-1 -: TAG_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;                                  // Cache starts empty.
    end else if (fill.write_tag_array) begin
      line_valid[wr_idx] <= 1'b1;                        // Line becomes usable next cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (fill.write_tag_array) begin
      tag_mem[wr_idx] <= wr_tag;
    end
  end

  // The processor side must respect the stall level.
  a_no_req_in_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !rd_en)
    else $error("rd_en raised while stall is high.");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it, and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -sv --assert --top-module cache_tb \
  -f all.f -Mdir "$BUILD_DIR" -o cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

"./$BUILD_DIR/cache_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed, see $LOG_FILE."
  exit 1
fi

//--- verif/cache_checker.sv
////////////////////////////////////////////////////////////
// Result checker for the cache testbench.
// Expects one load in flight at a time. Hits must return
// one cycle after rd_en, and misses take longer. Each fill
// word must be fetched from the next address of the line.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_checker (
  input  logic             clk,                     // Clock.
  input  logic             rst,                     // Synchronous reset.
  input  logic             rd_en,                   // Load strobe into the DUT.
  input  cache_pkg::addr_t rd_address,              // Load address into the DUT.
  input  logic             rd_valid,                // DUT result valid.
  input  cache_pkg::word_t rd_data,                 // DUT result word.
  input  logic             rd_hit,                  // DUT hit flag.
  input  logic             stall,                   // DUT stall level.
  input  cache_pkg::addr_t memory_address,          // Address the DUT presents to memory.
  input  logic             memory_data_valid,       // Memory word strobe.
  input  cache_pkg::word_t exp_data,                // Expected word from the trace.
  input  logic             exp_hit,                 // Expected hit flag from the trace.
  input  int               test_num,                // Number of the load in flight.
  output int               pass_count,              // Loads that matched.
  output int               fail_count               // Loads or results that did not.
);
  import cache_pkg::*;

  int    passed       = 0;                          // Running pass count.
  int    failed       = 0;                          // Running fail count.
  int    cycle_count  = 0;                          // Clock edges seen.
  int    req_cycle    = 0;                          // Edge at which rd_en was taken.
  logic  outstanding  = 1'b0;                       // A load waits for its result.
  addr_t req_addr     = '0;                         // Address of the load in flight.
  int    word_seen    = 0;                          // Fill words counted for this load.
  int    addr_errors  = 0;                          // Wrong fill addresses for this load.
  addr_t exp_mem_addr = '0;                         // Address the next fill word must use.

  assign pass_count = passed;
  assign fail_count = failed;

  always @(posedge clk) begin
    int errors;
    int latency;
    errors      = 0;
    cycle_count = cycle_count + 1;
    // Fill words run from the first word of the line upward, two bytes apart.
    if (!rst && outstanding && stall && memory_data_valid && word_seen < WORDS_PER_LINE) begin
      exp_mem_addr = (req_addr & ~addr_t'(LINE_BYTES - 1)) + addr_t'(MEM_STEP * word_seen);
      if (memory_address !== exp_mem_addr) begin
        $display("** Error at %0t: memory_address expected %h, got %h",
                 $time, exp_mem_addr, memory_address);
        addr_errors = addr_errors + 1;
      end
      word_seen = word_seen + 1;
    end
    if (!rst && rd_valid) begin
      if (!outstanding) begin
        $display("A load result appeared at %0t with no load in flight.", $time);
        failed = failed + 1;
      end else begin
        errors  = addr_errors;                      // Fill address faults count for this load.
        latency = cycle_count - req_cycle;          // Edges from request to result.
        if (rd_data !== exp_data) begin
          $display("** Error at %0t: rd_data expected %h, got %h", $time, exp_data, rd_data);
          errors = errors + 1;
        end
        if (rd_hit !== exp_hit) begin
          $display("** Error at %0t: rd_hit expected %b, got %b", $time, exp_hit, rd_hit);
          errors = errors + 1;
        end
        if (stall !== 1'b0) begin                   // Stall must be gone with the result.
          $display("** Error at %0t: stall expected 0, got %b", $time, stall);
          errors = errors + 1;
        end
        if (exp_hit && latency != 1) begin
          $display("** Error at %0t: rd_valid latency expected 1, got %0d", $time, latency);
          errors = errors + 1;
        end else if (!exp_hit && latency < 2) begin
          $display("** Error at %0t: rd_valid latency expected above 1, got %0d",
                   $time, latency);
          errors = errors + 1;
        end
        $display("Test %0d, load %h, %s: %s", test_num, req_addr,
                 exp_hit ? "hit" : "miss", (errors == 0) ? "pass" : "fail");
        if (errors == 0) begin
          passed = passed + 1;
        end else begin
          failed = failed + 1;
        end
      end
      outstanding = 1'b0;
    end
    if (!rst && rd_en) begin
      outstanding = 1'b1;                           // Start timing the new load.
      req_cycle   = cycle_count;
      req_addr    = rd_address;
      word_seen   = 0;
      addr_errors = 0;
    end
  end

endmodule

//--- verif/cache_tb.sv
////////////////////////////////////////////////////////////
// Testbench top for the read-only cache, NUM_LINES = 8.
// Loads and expected results come from the trace file, run
// from the project root. Memory answers after random gaps.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int          NUM_LINES       = 8;              // Lines in the DUT.
  localparam int          CLK_PERIOD      = 40;             // Clock period in ns.
  localparam int          RESET_CYCLES    = 3;              // Cycles with rst high.
  localparam int          CYCLES_PER_LOAD = 60;             // Worst case budget of one load.
  localparam logic [31:0] RAND_SEED       = 32'he49d_d45c;  // Seed for the memory gaps.
  localparam word_t       CONTENT_KEY     = 16'hc3a5;       // Memory word is address XOR key.

  logic  clk;                                       // Clock.
  logic  rst;                                       // Synchronous reset.
  logic  rd_en;                                     // Load strobe.
  addr_t rd_address;                                // Load address.
  logic  rd_valid;                                  // Load result valid.
  word_t rd_data;                                   // Load result word.
  logic  rd_hit;                                    // Load hit flag.
  logic  stall;                                     // Cache is busy.
  addr_t memory_address;                            // Address seen by memory.
  word_t memory_data;                               // Word returned by memory.
  logic  memory_data_valid = 1'b0;                  // Memory word strobe.
  int    gap_left = 0;                              // Idle cycles before the next pulse.

  word_t exp_data;                                  // Expected word of the current load.
  logic  exp_hit;                                   // Expected hit flag of the current load.
  int    test_num;                                  // Number of the current load.
  int    pass_count;                                // Loads that matched.
  int    fail_count;                                // Loads or results that did not.
  logic  setup_failed = 1'b0;                       // Trace could not be used.
  logic  trace_loaded = 1'b0;                       // Trace is in the queues.
  addr_t addr_q [$];                                // Load addresses from the trace.
  word_t data_q [$];                                // Expected words from the trace.
  logic  hit_q [$];                                 // Expected hit flags from the trace.

  cache_top #(.NUM_LINES(NUM_LINES)) dut_i (
    .clk               (clk),
    .rst               (rst),
    .rd_en             (rd_en),
    .rd_address        (rd_address),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data),
    .rd_hit            (rd_hit),
    .stall             (stall),
    .memory_address    (memory_address),
    .memory_data       (memory_data),
    .memory_data_valid (memory_data_valid)
  );

  cache_checker checker_i (
    .clk               (clk),
    .rst               (rst),
    .rd_en             (rd_en),
    .rd_address        (rd_address),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data),
    .rd_hit            (rd_hit),
    .stall             (stall),
    .memory_address    (memory_address),
    .memory_data_valid (memory_data_valid),
    .exp_data          (exp_data),
    .exp_hit           (exp_hit),
    .test_num          (test_num),
    .pass_count        (pass_count),
    .fail_count        (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;           // 40 ns period.
  end

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////
  assign memory_data = memory_address ^ CONTENT_KEY; // Read port follows the address at once.

  always @(posedge clk) begin
    if (rst || !stall) begin
      memory_data_valid <= 1'b0;                    // Quiet while no fill is waiting.
      gap_left          <= $urandom_range(5, 0);
    end else if (gap_left == 0) begin
      memory_data_valid <= 1'b1;                    // One word per pulse.
      gap_left          <= $urandom_range(5, 0);    // Gap of 0 gives back to back words.
    end else begin
      memory_data_valid <= 1'b0;
      gap_left          <= gap_left - 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load driver
  ////////////////////////////////////////////////////////////
  task automatic issue_load(input addr_t addr, input word_t data, input logic hit,
                            input int num);
    @(posedge clk);
    while (stall) @(posedge clk);                   // New loads only while the cache is free.
    rd_en      <= 1'b1;
    rd_address <= addr;
    exp_data   <= data;                             // Checker reads these at rd_valid.
    exp_hit    <= hit;
    test_num   <= num;
    @(posedge clk);
    rd_en <= 1'b0;                                  // Single cycle strobe.
    while (!rd_valid) @(posedge clk);               // The watchdog bounds this wait.
  endtask

  initial begin
    int         fd;                                 // Trace file handle.
    string      line;                               // One line of the trace.
    addr_t      addr;
    word_t      data;
    logic [7:0] hit_flag;
    rst        <= 1'b1;
    rd_en      <= 1'b0;
    rd_address <= '0;
    exp_data   <= '0;
    exp_hit    <= 1'b0;
    test_num   <= 0;
    void'($urandom(RAND_SEED));                     // Seeded once for the whole run.
    fd = $fopen("verif/cache_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file verif/cache_trace.txt.");
      setup_failed = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) != "#" && $sscanf(line, "%h %h %h", addr, data, hit_flag) == 3) begin
          addr_q.push_back(addr);
          data_q.push_back(data);
          hit_q.push_back(hit_flag != 0);
        end
      end
      $fclose(fd);
      if (addr_q.size() == 0) begin
        $display("The trace file holds no loads.");
        setup_failed = 1'b1;
      end
    end
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    if (!setup_failed) begin
      foreach (addr_q[i]) begin
        issue_load(addr_q[i], data_q[i], hit_q[i], i + 1);
      end
    end
    repeat (2) @(posedge clk);
    $display("Tests run: %0d, passed: %0d, failed: %0d", addr_q.size(), pass_count, fail_count);
    if (!setup_failed && fail_count == 0 && pass_count == addr_q.size()) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, sized from the number of loads in the trace.
  initial begin
    wait (trace_loaded);
    repeat (addr_q.size() * CYCLES_PER_LOAD + RESET_CYCLES + 10) @(posedge clk);
    $display("Timeout: the loads did not complete within %0d cycles.",
             addr_q.size() * CYCLES_PER_LOAD);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verif/cache_trace.txt
# load_address expected_data expected_hit, all in hex
# expected_data is the word address (bit 0 cleared) XOR c3a5
0124 c281 0
012a c28f 1
0120 c285 1
012f c28b 1
0300 c0a5 0
0312 c0b7 0
0334 c091 0
0347 c0e3 0
0358 c0fd 0
036b c0cf 0
037c c0d9 0
052e c68b 0
0522 c687 1
0124 c281 0
2006 e3a3 0
2010 e3b5 0
2020 e385 0
2030 e395 0
2040 e3e5 0
2050 e3f5 0
2060 e3c5 0
2070 e3d5 0
200e e3ab 1
201c e3b9 1
202a e38f 1
2038 e39d 1
2044 e3e1 1
2052 e3f7 1
2068 e3cd 1
207f e3db 1
